// File: flist.f
+incdir+verilog
verilog/videoPkg.sv
verilog/tmdsPkg.sv
verilog/tmdsEncoder.sv
verilog/tmdsSerializer.sv
verilog/tmdsTransmitter.sv
testbench/tmdsTransmitter_props.sv
testbench/tmdsTransmitter_tb.sv

// File: run.sh
#!/bin/sh
# build and run the TMDS transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tmdsTransmitter_tb -o simv || exit 1
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
grep -qx "=== PASS ===" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: testbench/tmdsTransmitter_tb.sv
`timescale 1ns/1ps
`include "tmds_macros.svh"
`default_nettype none

module tmdsTransmitter_tb;

    localparam int pixelPeriod = 40;           // ns
    localparam int latency     = 3;            // words from drive edge to wire
    localparam int burstBeats  = 12;           // four sync codes, three each
    localparam int videoBeats  = 80;
    localparam int runBeats    = 40;
    localparam int numBeats    = 4 * burstBeats + 2 * videoBeats + 2 * runBeats;
    localparam int timeoutNs   = (numBeats + 8 + 40) * pixelPeriod;

    // expected word for one driven beat
    typedef struct {
        tmdsPkg::tmdsLanesT chars;
        logic               de;
        time                driven;
    } expectT;

    // one word taken off the wire
    typedef struct {
        tmdsPkg::tmdsLanesT chars;
        tmdsPkg::tmdsCharT  clkWord;
        time                start;
    } wordT;

    logic                pixelClk = 1'b0;
    logic                tmdsClk = 1'b1;        // rising edges line up with pixelClk
    logic                rstN = 1'b0;
    videoPkg::videoBeatT beat = '0;
    tmdsPkg::tmdsPortT   hdmi;

    expectT expQ[$];
    wordT   obsQ[$];
    int     seed = 32'ha3a6_ece2;
    int     refDisp[3] = '{0, 0, 0};           // reference encoder state per lane
    int     errCount = 0;
    int     checkCount = 0;
    int     compared = 0;

    // --------------------
    // clocks and DUT
    // --------------------
    always #20 pixelClk = ~pixelClk;
    always #2 tmdsClk = ~tmdsClk;               // ten per pixel, edges aligned

    tmdsTransmitter dut (
        .pixelClk (pixelClk),
        .tmdsClk  (tmdsClk),
        .rstN     (rstN),
        .beat     (beat),
        .hdmi     (hdmi)
    );

    // --------------------
    // reference encoder
    // --------------------
    function automatic tmdsPkg::tmdsCharT refEncode(input videoPkg::videoBeatT b,
                                                    input int lane, inout int disp);
        logic [7:0]        d;
        logic [8:0]        qm;
        logic              xnorMode;
        int                n1;
        int                n1q;
        int                n0q;
        tmdsPkg::tmdsCharT q;
        d = (lane == 0) ? b.pixel.blue : (lane == 1) ? b.pixel.green : b.pixel.red;
        if (!b.sync.de) begin
            disp = 0;                           // blanking clears the count
            if (lane != 0) return `TMDS_CTRL_00;
            case ({b.sync.vsync, b.sync.hsync})
                2'b00:   return `TMDS_CTRL_00;
                2'b01:   return `TMDS_CTRL_01;
                2'b10:   return `TMDS_CTRL_10;
                default: return `TMDS_CTRL_11;
            endcase
        end
        n1 = $countones(d);
        xnorMode = (n1 > 4) || (n1 == 4 && d[0] == 1'b0);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = xnorMode ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !xnorMode;
        n1q = $countones(qm[7:0]);
        n0q = 8 - n1q;
        if (disp == 0 || n1q == n0q) begin
            q = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            disp = qm[8] ? disp + n1q - n0q : disp + n0q - n1q;
        end else if ((disp > 0 && n1q > n0q) || (disp < 0 && n0q > n1q)) begin
            q = {1'b1, qm[8], ~qm[7:0]};
            disp = disp + (qm[8] ? 2 : 0) + n0q - n1q;
        end else begin
            q = {1'b0, qm[8], qm[7:0]};
            disp = disp - (qm[8] ? 0 : 2) + n1q - n0q;
        end
        return q;
    endfunction

    // --------------------
    // compare tasks
    // --------------------
    task automatic checkChar(input string name, input tmdsPkg::tmdsCharT exp,
                             input tmdsPkg::tmdsCharT act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("error %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic checkDiff(input string name, input tmdsPkg::tmdsDiffT exp,
                             input tmdsPkg::tmdsDiffT act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("error %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic driveBeat(input videoPkg::videoBeatT b);
        expectT e;
        e.chars.blue  = refEncode(b, 0, refDisp[0]);
        e.chars.green = refEncode(b, 1, refDisp[1]);
        e.chars.red   = refEncode(b, 2, refDisp[2]);
        e.de          = b.sync.de;
        e.driven      = $time;
        expQ.push_back(e);
        beat <= b;                              // sampled at the next edge
        @(posedge pixelClk);
    endtask

    task automatic ctrlBurst();
        videoPkg::videoBeatT b;
        for (int s = 0; s < 4; s++) begin
            repeat (burstBeats / 4) begin
                b.pixel = 24'($random(seed));   // ignored in blanking
                b.sync.de = 1'b0;
                b.sync.hsync = s[0];
                b.sync.vsync = s[1];
                driveBeat(b);
            end
        end
    endtask

    task automatic videoBurst(input int count);
        videoPkg::videoBeatT b;
        repeat (count) begin
            b.pixel = 24'($random(seed));
            b.sync = '{de: 1'b1, hsync: 1'b0, vsync: 1'b0};
            driveBeat(b);
        end
    endtask

    task automatic constRun(input logic [7:0] value);
        videoPkg::videoBeatT b;
        b.pixel = '{red: value, green: value, blue: value};
        b.sync = '{de: 1'b1, hsync: 1'b0, vsync: 1'b0};
        repeat (runBeats) driveBeat(b);
    endtask

    initial begin
        repeat (8) @(posedge pixelClk);
        rstN <= 1'b1;
        ctrlBurst();
        videoBurst(videoBeats);
        ctrlBurst();
        constRun(8'h00);                        // pushes disparity one way
        constRun(8'hff);                        // and then the other
        ctrlBurst();
        videoBurst(videoBeats);
        ctrlBurst();                            // flush tail
        wait (compared == numBeats);
        $display("checks %0d errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // --------------------
    // lane deserialiser
    // --------------------
    logic              prevClk = 1'b0;
    int                bitIdx = 0;
    tmdsPkg::tmdsCharT shiftIn[4];             // blue, green, red, clock
    time               wordStart = 0;

    always @(negedge tmdsClk) begin : deserialize
        wordT w;
        if (!rstN) begin
            prevClk = 1'b0;                     // first word after reset counts
            bitIdx = 0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                checkDiff($sformatf("hdmi.data[%0d]", i),
                          '{pos: hdmi.data[i].pos, neg: ~hdmi.data[i].pos}, hdmi.data[i]);
            end
            checkDiff("hdmi.clk", '{pos: hdmi.clk.pos, neg: ~hdmi.clk.pos}, hdmi.clk);
            if (hdmi.clk.pos && !prevClk) begin
                bitIdx = 0;                     // rising clock lane marks bit 0
                wordStart = $time - 2;
            end
            prevClk = hdmi.clk.pos;
            if (bitIdx < 10) begin
                for (int i = 0; i < 3; i++) shiftIn[i][bitIdx] = hdmi.data[i].pos;
                shiftIn[3][bitIdx] = hdmi.clk.pos;
                if (bitIdx == 9) begin
                    w.chars = '{blue: shiftIn[0], green: shiftIn[1], red: shiftIn[2]};
                    w.clkWord = shiftIn[3];
                    w.start = wordStart;
                    obsQ.push_back(w);
                end
                bitIdx++;
            end
        end
    end

    // --------------------
    // word compare
    // --------------------
    initial begin : compareWords
        wordT   w;
        expectT e;
        int     dropped;
        int     obsDisp[3];
        tmdsPkg::tmdsCharT laneChar[3];
        dropped = 0;
        obsDisp = '{0, 0, 0};
        forever begin
            wait (obsQ.size() > 0);
            w = obsQ.pop_front();
            checkChar("clk lane", `TMDS_CLOCK_PATTERN, w.clkWord);
            if (dropped < latency) begin
                dropped++;                      // words already on the wire at reset
            end else if (compared < numBeats && expQ.size() > 0) begin
                e = expQ.pop_front();
                checkChar("blue", e.chars.blue, w.chars.blue);
                checkChar("green", e.chars.green, w.chars.green);
                checkChar("red", e.chars.red, w.chars.red);
                if (w.start - e.driven != latency * pixelPeriod) begin
                    errCount++;
                    $display("word for the beat driven at %0t started at %0t, not %0d ns later",
                             e.driven, w.start, latency * pixelPeriod);
                end
                laneChar = '{w.chars.blue, w.chars.green, w.chars.red};
                for (int i = 0; i < 3; i++) begin
                    obsDisp[i] = e.de ? obsDisp[i] + 2 * $countones(laneChar[i]) - 10 : 0;
                    if (obsDisp[i] > 10 || obsDisp[i] < -10) begin
                        errCount++;
                        $display("lane %0d running disparity reached %0d at %0t",
                                 i, obsDisp[i], $time);
                    end
                end
                compared++;
            end
        end
    end

    // --------------------
    // watchdog
    // --------------------
    initial begin
        #(timeoutNs);
        $display("timeout: only %0d of %0d words were compared", compared, numBeats);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tmdsTransmitter_props.sv
`timescale 1ns/1ps
`include "tmds_macros.svh"
`default_nettype none

module tmdsTransmitter_props (
    input wire logic                pixelClk,
    input wire logic                tmdsClk,
    input wire logic                rstN,
    input wire videoPkg::videoBeatT beat,
    input wire tmdsPkg::tmdsLanesT  chars,
    input wire tmdsPkg::tmdsPortT   hdmi
);

    tmdsPkg::tmdsPeriodE periodD1;             // period of the stage one word
    tmdsPkg::tmdsPeriodE periodD2;             // period of chars right now
    logic [4:0]          tmdsCount;            // warm up for $past

    always_ff @(posedge pixelClk or negedge rstN) begin
        if (!rstN) begin
            periodD1 <= tmdsPkg::ctrlPeriod;
            periodD2 <= tmdsPkg::ctrlPeriod;
        end else begin
            periodD1 <= beat.sync.de ? tmdsPkg::videoPeriod : tmdsPkg::ctrlPeriod;
            periodD2 <= periodD1;
        end
    end

    always_ff @(posedge tmdsClk or negedge rstN) begin
        if (!rstN) tmdsCount <= '0;
        else if (tmdsCount != 5'd31) tmdsCount <= tmdsCount + 5'd1;
    end

    function automatic logic isCtrl(input tmdsPkg::tmdsCharT c);
        return c == `TMDS_CTRL_00 || c == `TMDS_CTRL_01 ||
               c == `TMDS_CTRL_10 || c == `TMDS_CTRL_11;
    endfunction

    // --------------------
    // pins
    // --------------------
    complementPairs: assert property (@(posedge tmdsClk)
        {hdmi.data[0].neg, hdmi.data[1].neg, hdmi.data[2].neg, hdmi.clk.neg} ==
        ~{hdmi.data[0].pos, hdmi.data[1].pos, hdmi.data[2].pos, hdmi.clk.pos})
        else $error("differential pair not complementary");

    clockLaneRepeats: assert property (@(posedge tmdsClk) disable iff (!rstN)
        (tmdsCount > 5'd12) |-> (hdmi.clk.pos == $past(hdmi.clk.pos, 10)))
        else $error("clock lane pattern broken");

    // --------------------
    // characters
    // --------------------
    ctrlSymbols: assert property (@(posedge pixelClk) disable iff (!rstN)
        (periodD2 == tmdsPkg::ctrlPeriod) |->
        (isCtrl(chars.blue) && isCtrl(chars.green) && isCtrl(chars.red)))
        else $error("non control character in blanking");

endmodule

bind tmdsTransmitter tmdsTransmitter_props props (
    .pixelClk (pixelClk),
    .tmdsClk  (tmdsClk),
    .rstN     (rstN),
    .beat     (beat),
    .chars    (chars),
    .hdmi     (hdmi)
);

`default_nettype wire

// File: verilog/tmdsTransmitter.sv
`timescale 1ns/1ps
`default_nettype none

module tmdsTransmitter (
    input  wire logic               pixelClk,
    input  wire logic               tmdsClk,   // 10x pixelClk
    input  wire logic               rstN,
    input  wire videoPkg::videoBeatT beat,     // one pixel per clock
    output wire tmdsPkg::tmdsPortT  hdmi
);

    tmdsPkg::tmdsLanesT chars;                 // encoder to serialiser

    // --------------------
    // 8b/10b encoders
    // --------------------
    tmdsEncoder #(
        .carriesSync (1'b1)                     // hsync/vsync in blanking
    ) encodeBlue (
        .pixelClk (pixelClk),
        .rstN     (rstN),
        .data     (beat.pixel.blue),
        .sync     (beat.sync),
        .tmdsChar (chars.blue)
    );

    tmdsEncoder #(
        .carriesSync (1'b0)                     // ctrl 00 only
    ) encodeGreen (
        .pixelClk (pixelClk),
        .rstN     (rstN),
        .data     (beat.pixel.green),
        .sync     (beat.sync),
        .tmdsChar (chars.green)
    );

    tmdsEncoder #(
        .carriesSync (1'b0)
    ) encodeRed (
        .pixelClk (pixelClk),
        .rstN     (rstN),
        .data     (beat.pixel.red),
        .sync     (beat.sync),
        .tmdsChar (chars.red)
    );

    // --------------------
    // serialiser
    // --------------------
    // crosses into the tmds clock, also builds the clock lane
    tmdsSerializer serialize (
        .tmdsClk (tmdsClk),
        .rstN    (rstN),
        .chars   (chars),
        .hdmi    (hdmi)
    );

endmodule

`default_nettype wire

// File: verilog/tmdsSerializer.sv
`timescale 1ns/1ps
`include "tmds_macros.svh"
`default_nettype none

module tmdsSerializer (
    input  wire logic               tmdsClk,   // 10x pixelClk, edge aligned
    input  wire logic               rstN,
    input  wire tmdsPkg::tmdsLanesT chars,     // from the pixel domain
    output tmdsPkg::tmdsPortT       hdmi
);

    localparam int phaseBits = $clog2(`TMDS_SERIAL_RATIO);
    localparam logic [phaseBits-1:0] lastPhase = phaseBits'(`TMDS_SERIAL_RATIO - 1);

    // --------------------
    // phase counter
    // --------------------
    logic [phaseBits-1:0] phase;               // bit index on the wire
    logic                 loadWord;

    assign loadWord = (phase == lastPhase);

    always_ff @(posedge tmdsClk or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
        end else if (loadWord) begin
            phase <= '0;                          // wrap every ten bits
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // --------------------
    // shift registers
    // --------------------
    tmdsPkg::tmdsCharT laneChar [`TMDS_DATA_LANES];   // chars split per lane
    tmdsPkg::tmdsCharT dataShift [`TMDS_DATA_LANES];
    tmdsPkg::tmdsCharT clkShift;

    always_comb begin
        laneChar[0] = chars.blue;                 // lane order matches hdmi.data
        laneChar[1] = chars.green;
        laneChar[2] = chars.red;
    end

    // same clock source, no synchroniser on chars
    always_ff @(posedge tmdsClk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `TMDS_DATA_LANES; i++) begin
                dataShift[i] <= `TMDS_CTRL_00;
            end
            clkShift <= `TMDS_CLOCK_PATTERN;       // lines up with phase 0
        end else if (loadWord) begin
            for (int i = 0; i < `TMDS_DATA_LANES; i++) begin
                dataShift[i] <= laneChar[i];
            end
            clkShift <= `TMDS_CLOCK_PATTERN;
        end else begin
            for (int i = 0; i < `TMDS_DATA_LANES; i++) begin
                dataShift[i] <= dataShift[i] >> 1;  // lsb first
            end
            clkShift <= clkShift >> 1;
        end
    end

    // --------------------
    // differential pins
    // --------------------
    always_comb begin
        for (int i = 0; i < `TMDS_DATA_LANES; i++) begin
            hdmi.data[i].pos = dataShift[i][0];
            hdmi.data[i].neg = ~dataShift[i][0];  // complement pair
        end
        hdmi.clk.pos = clkShift[0];               // high for bits 0..4
        hdmi.clk.neg = ~clkShift[0];
    end

endmodule

`default_nettype wire

// File: verilog/tmdsEncoder.sv
`timescale 1ns/1ps
`include "tmds_macros.svh"
`default_nettype none

module tmdsEncoder #(
    parameter bit carriesSync = 1'b0               // 1 on blue only
) (
    input  wire logic                        pixelClk,
    input  wire logic                        rstN,
    input  wire logic [`PIXEL_CHAN_BITS-1:0] data,
    input  wire videoPkg::videoSyncT         sync,
    output tmdsPkg::tmdsCharT                tmdsChar
);

    localparam int msb = `PIXEL_CHAN_BITS;       // index of the qm flag bit

    // --------------------
    // stage one
    // --------------------
    logic [3:0]   dataOnes;                     // 0..8
    logic         useXnor;
    logic [msb:0] qm;                           // transition minimised word
    logic [3:0]   qmOnes;                       // ones in qm[7:0]
    logic [1:0]   ctrlSel;                      // {vsync, hsync} or 00

    logic [msb:0]        qmReg;
    logic [3:0]          qmOnesReg;
    tmdsPkg::tmdsPeriodE periodReg;
    logic [1:0]          ctrlReg;

    always_comb begin
        dataOnes = '0;
        for (int i = 0; i < `PIXEL_CHAN_BITS; i++) begin
            dataOnes = dataOnes + 4'(data[i]);
        end
        // xnor chain when the byte is ones heavy
        useXnor = (dataOnes > 4'd4) || ((dataOnes == 4'd4) && !data[0]);
        qm[0] = data[0];
        for (int i = 1; i < `PIXEL_CHAN_BITS; i++) begin
            qm[i] = useXnor ? ~(qm[i-1] ^ data[i]) : (qm[i-1] ^ data[i]);
        end
        qm[msb] = ~useXnor;                       // 1 means xor was used
        qmOnes = '0;
        for (int i = 0; i < `PIXEL_CHAN_BITS; i++) begin
            qmOnes = qmOnes + 4'(qm[i]);
        end
    end

    // green and red never see sync
    assign ctrlSel = carriesSync ? {sync.vsync, sync.hsync} : 2'b00;

    always_ff @(posedge pixelClk) begin
        qmReg     <= qm;                          // payload, no reset
        qmOnesReg <= qmOnes;
    end

    // --------------------
    // stage two
    // --------------------
    logic signed [5:0] disparity;               // running ones minus zeros
    logic signed [5:0] nextDisp;
    logic signed [5:0] balance;                 // n1 - n0 of qm[7:0]
    tmdsPkg::tmdsCharT nextChar;

    always_comb begin
        balance  = $signed({1'b0, qmOnesReg, 1'b0}) - 6'sd8;  // 2*n1 - 8
        nextChar = tmdsChar;
        nextDisp = disparity;
        if (periodReg == tmdsPkg::ctrlPeriod) begin
            nextDisp = '0;                        // blanking restarts the count
            case (ctrlReg)
                2'b00:   nextChar = `TMDS_CTRL_00;
                2'b01:   nextChar = `TMDS_CTRL_01;
                2'b10:   nextChar = `TMDS_CTRL_10;
                default: nextChar = `TMDS_CTRL_11;
            endcase
        end else if ((disparity == 6'sd0) || (balance == 6'sd0)) begin
            // no bias either way, qm[8] picks the inversion
            nextChar = {~qmReg[msb], qmReg[msb],
                        qmReg[msb] ? qmReg[msb-1:0] : ~qmReg[msb-1:0]};
            nextDisp = qmReg[msb] ? disparity + balance : disparity - balance;
        end else if (((disparity > 6'sd0) && (balance > 6'sd0)) ||
                     ((disparity < 6'sd0) && (balance < 6'sd0))) begin
            // same sign as the backlog, invert the data bits
            nextChar = {1'b1, qmReg[msb], ~qmReg[msb-1:0]};
            nextDisp = disparity + $signed({4'b0000, qmReg[msb], 1'b0}) - balance;
        end else begin
            nextChar = {1'b0, qmReg[msb], qmReg[msb-1:0]};
            nextDisp = disparity - $signed({4'b0000, ~qmReg[msb], 1'b0}) + balance;
        end
    end

    always_ff @(posedge pixelClk or negedge rstN) begin
        if (!rstN) begin
            periodReg <= tmdsPkg::ctrlPeriod;
            ctrlReg   <= 2'b00;
            disparity <= '0;
            tmdsChar  <= `TMDS_CTRL_00;
        end else begin
            periodReg <= sync.de ? tmdsPkg::videoPeriod : tmdsPkg::ctrlPeriod;
            ctrlReg   <= ctrlSel;
            disparity <= nextDisp;
            tmdsChar  <= nextChar;                // two edges after capture
        end
    end

endmodule

`default_nettype wire

// File: verilog/tmdsPkg.sv
`include "tmds_macros.svh"
`default_nettype none

package tmdsPkg;

    // --------------------
    // characters
    // --------------------
    typedef logic [`TMDS_CHAR_BITS-1:0] tmdsCharT;  // bit 0 sent first

    // parallel word set for one pixel, 30 bits
    typedef struct packed {
        tmdsCharT blue;   // also carries hsync/vsync in blanking
        tmdsCharT green;
        tmdsCharT red;
    } tmdsLanesT;

    // encoder period, held in stage one
    typedef enum logic {
        ctrlPeriod  = 1'b0,  // blanking, control symbols
        videoPeriod = 1'b1   // de high, 8b/10b data
    } tmdsPeriodE;

    // --------------------
    // pins
    // --------------------
    typedef struct packed {
        logic pos;
        logic neg;  // always ~pos
    } tmdsDiffT;

    // top level output, 8 bits
    typedef struct packed {
        tmdsDiffT [`TMDS_DATA_LANES-1:0] data;  // [0] blue .. [2] red
        tmdsDiffT                        clk;   // pixel rate clock lane
    } tmdsPortT;

endpackage

`default_nettype wire

// File: verilog/videoPkg.sv
`include "tmds_macros.svh"
`default_nettype none

package videoPkg;

    // --------------------
    // pixel payload
    // --------------------
    typedef struct packed {
        logic [`PIXEL_CHAN_BITS-1:0] red;    // top byte, lane 2
        logic [`PIXEL_CHAN_BITS-1:0] green;  // lane 1
        logic [`PIXEL_CHAN_BITS-1:0] blue;   // low byte, lane 0
    } rgbPixelT;

    // --------------------
    // timing signals
    // --------------------
    typedef struct packed {
        logic de;     // active video
        logic hsync;  // raw polarity, no inversion here
        logic vsync;
    } videoSyncT;

    // one pixel clock worth of video, 27 bits
    typedef struct packed {
        rgbPixelT  pixel;
        videoSyncT sync;
    } videoBeatT;

endpackage

`default_nettype wire

// File: verilog/tmds_macros.svh
`ifndef TMDS_MACROS_SVH
`define TMDS_MACROS_SVH
`default_nettype none

// --------------------
// widths and ratios
// --------------------
`define TMDS_CHAR_BITS     10          // one tmds character
`define PIXEL_CHAN_BITS    8           // bits per colour channel
`define TMDS_DATA_LANES    3           // blue, green, red
`define TMDS_SERIAL_RATIO  10          // tmds clocks per pixel clock

// --------------------
// control symbols
// --------------------
// indexed by {vsync, hsync}, bit 0 goes out first
`define TMDS_CTRL_00       10'b1101010100
`define TMDS_CTRL_01       10'b0010101011
`define TMDS_CTRL_10       10'b0101010100
`define TMDS_CTRL_11       10'b1010101011

// clock lane word, lsb first gives 1111100000 on the wire
`define TMDS_CLOCK_PATTERN 10'b0000011111

`default_nettype wire
`endif
